// ==== common/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	localparam int NUM_REGS = 8;
	localparam int NUM_UNITS = 3;
	localparam int NUM_RD_PORTS = 6;

	typedef logic [15:0] word_t;
	typedef logic [2:0]  reg_addr_t;
	typedef logic [4:0]  opcode_t;

	// Opcode field sits in instr[15:11]
	localparam opcode_t OPC_ADD_IMM = 5'b00000;
	localparam opcode_t OPC_ADD_REG = 5'b00001;
	localparam opcode_t OPC_SUB_IMM = 5'b00010;
	localparam opcode_t OPC_SUB_REG = 5'b00011;
	localparam opcode_t OPC_LD_BASE = 5'b10100;
	localparam opcode_t OPC_LD_PC   = 5'b10101;
	localparam opcode_t OPC_ST_BASE = 5'b10110;
	localparam opcode_t OPC_ST_PC   = 5'b10111;

	typedef enum logic [2:0] {op_add, op_sub, op_load, op_store, op_nop} op_e;
	typedef enum logic [1:0] {unit_alu0, unit_alu1, unit_mem0} unit_e;
	typedef enum logic [1:0] {src_reg, src_imm, src_pc1} operand_src_e;

	typedef struct packed {
		logic         valid;
		op_e          op;
		reg_addr_t    dest;
		operand_src_e src0_sel;
		reg_addr_t    src0_reg;
		operand_src_e src1_sel;
		reg_addr_t    src1_reg;
		word_t        imm;
		word_t        pc;
	} decoded_instr_t;

	typedef struct packed {
		logic      valid;
		op_e       op;
		reg_addr_t dest;
		word_t     operand_a;
		word_t     operand_b;
		word_t     store_data;
	} dispatch_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t dest;
		word_t     value;
	} complete_t;

	typedef struct packed {
		logic  valid;
		word_t addr;
		word_t data;
	} store_t;

endpackage

`default_nettype wire

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_unit
	import cpu_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  rst_n,
	input  wire logic  stall,
	input  wire word_t instr,
	output word_t      fetch_addr,
	output word_t      held_instr,
	output word_t      held_pc,
	output logic       held_valid
);

	word_t pc;

	assign fetch_addr = pc;

	// PC and held word both freeze under stall
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
			held_instr <= '0;
			held_pc <= '0;
			held_valid <= 1'b0;
		end else if (!stall) begin
			pc <= pc + word_t'(1);
			held_instr <= instr;
			held_pc <= pc;
			held_valid <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== decode/instr_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decoder
	import cpu_pkg::*;
(
	input  wire word_t  held_instr,
	input  wire word_t  held_pc,
	input  wire logic   held_valid,
	output decoded_instr_t decoded
);

	opcode_t opcode;
	word_t   imm5;
	word_t   imm8;

	assign opcode = held_instr[15:11];
	assign imm5 = {{11{held_instr[4]}}, held_instr[4:0]};
	assign imm8 = {{8{held_instr[7]}}, held_instr[7:0]};

	always_comb begin
		decoded.valid = held_valid;
		decoded.op = op_nop;
		decoded.dest = held_instr[10:8];
		decoded.src0_sel = src_reg;
		decoded.src0_reg = held_instr[7:5];
		decoded.src1_sel = src_imm;
		decoded.src1_reg = held_instr[2:0];
		decoded.imm = imm5;
		decoded.pc = held_pc;

		case (opcode)
			OPC_ADD_IMM: decoded.op = op_add;
			OPC_ADD_REG: begin
				decoded.op = op_add;
				decoded.src1_sel = src_reg;
			end
			OPC_SUB_IMM: decoded.op = op_sub;
			OPC_SUB_REG: begin
				decoded.op = op_sub;
				decoded.src1_sel = src_reg;
			end
			OPC_LD_BASE: decoded.op = op_load;
			OPC_ST_BASE: decoded.op = op_store;
			// PC-relative forms use the wide offset
			OPC_LD_PC: begin
				decoded.op = op_load;
				decoded.src0_sel = src_pc1;
				decoded.imm = imm8;
			end
			OPC_ST_PC: begin
				decoded.op = op_store;
				decoded.src0_sel = src_pc1;
				decoded.imm = imm8;
			end
			default: decoded.op = op_nop;
		endcase
	end

endmodule

`default_nettype wire

// ==== decode/scoreboard.sv ====
`timescale 1ns/1ns
`default_nettype none

module scoreboard
	import cpu_pkg::*;
(
	input  wire logic           clk,
	input  wire logic           rst_n,
	input  wire decoded_instr_t decoded,
	input  wire complete_t      alu0_done,
	input  wire complete_t      alu1_done,
	input  wire complete_t      mem_done,
	input  wire logic           mem_store_done,
	output reg_addr_t           rd_addr [NUM_RD_PORTS],
	input  wire word_t          rd_data [NUM_RD_PORTS],
	output dispatch_t           alu0_disp,
	output dispatch_t           alu1_disp,
	output dispatch_t           mem_disp,
	output logic                stall
);

	typedef enum logic [1:0] {st_idle, st_waiting, st_executing} unit_state_e;

	typedef struct packed {
		operand_src_e sel;
		reg_addr_t    rgn;
		logic         ready;
		unit_e        producer;
	} src_entry_t;

	// Source 2 is the store data register
	typedef struct packed {
		unit_state_e      state;
		op_e              op;
		reg_addr_t        dest;
		word_t            imm;
		word_t            pc;
		src_entry_t [2:0] src;
	} unit_entry_t;

	unit_entry_t units [NUM_UNITS];
	logic        pend_valid [NUM_REGS];
	unit_e       pend_unit [NUM_REGS];

	complete_t   done_arr [NUM_UNITS];
	logic        finish [NUM_UNITS];
	logic        reg_busy [NUM_REGS];
	logic        disp_go [NUM_UNITS];
	dispatch_t   disp_arr [NUM_UNITS];

	logic        is_arith;
	logic        is_mem;
	logic        writes_dest;
	logic        unit_free;
	logic        dest_busy;
	logic        war;
	logic        issue;
	unit_e       target;
	unit_entry_t new_entry;

	function automatic src_entry_t make_src(operand_src_e sel, reg_addr_t rgn, logic busy,
			unit_e prod);
		src_entry_t s;
		s.sel = sel;
		s.rgn = rgn;
		s.ready = (sel != src_reg) || !busy;
		s.producer = prod;
		return s;
	endfunction

	function automatic word_t src_value(operand_src_e sel, word_t rd, word_t imm, word_t pc);
		case (sel)
			src_reg: return rd;
			src_pc1: return pc + word_t'(1);
			default: return imm;
		endcase
	endfunction

	assign done_arr[unit_alu0] = alu0_done;
	assign done_arr[unit_alu1] = alu1_done;
	assign done_arr[unit_mem0] = mem_done;

	assign alu0_disp = disp_arr[unit_alu0];
	assign alu1_disp = disp_arr[unit_alu1];
	assign mem_disp = disp_arr[unit_mem0];

	always_comb begin
		for (int u = 0; u < NUM_UNITS; u++) begin
			finish[u] = done_arr[u].valid;
		end
		finish[unit_mem0] = mem_done.valid || mem_store_done;
		// A writer completing this cycle no longer blocks a new reader
		for (int r = 0; r < NUM_REGS; r++) begin
			reg_busy[r] = pend_valid[r] && !done_arr[pend_unit[r]].valid;
		end
	end

	////////////////////
	// Issue
	////////////////////

	always_comb begin
		is_arith = decoded.op inside {op_add, op_sub};
		is_mem = decoded.op inside {op_load, op_store};
		writes_dest = is_arith || (decoded.op == op_load);
		unit_free = 1'b0;
		target = unit_alu0;
		if (is_arith) begin
			if (units[unit_alu0].state == st_idle) begin
				unit_free = 1'b1;
			end else if (units[unit_alu1].state == st_idle) begin
				unit_free = 1'b1;
				target = unit_alu1;
			end
		end else if (is_mem) begin
			unit_free = (units[unit_mem0].state == st_idle);
			target = unit_mem0;
		end

		dest_busy = writes_dest && pend_valid[decoded.dest];
		war = 1'b0;
		for (int u = 0; u < NUM_UNITS; u++) begin
			for (int k = 0; k < 3; k++) begin
				if (writes_dest && units[u].state == st_waiting &&
						units[u].src[k].sel == src_reg &&
						units[u].src[k].rgn == decoded.dest) begin
					war = 1'b1;
				end
			end
		end

		stall = decoded.valid && (is_arith || is_mem) && (!unit_free || dest_busy || war);
		issue = decoded.valid && unit_free && !stall;

		new_entry.state = st_waiting;
		new_entry.op = decoded.op;
		new_entry.dest = decoded.dest;
		new_entry.imm = decoded.imm;
		new_entry.pc = decoded.pc;
		new_entry.src[0] = make_src(decoded.src0_sel, decoded.src0_reg,
			reg_busy[decoded.src0_reg], pend_unit[decoded.src0_reg]);
		new_entry.src[1] = make_src(decoded.src1_sel, decoded.src1_reg,
			reg_busy[decoded.src1_reg], pend_unit[decoded.src1_reg]);
		if (decoded.op == op_store) begin
			new_entry.src[2] = make_src(src_reg, decoded.dest,
				reg_busy[decoded.dest], pend_unit[decoded.dest]);
		end else begin
			new_entry.src[2] = make_src(src_imm, decoded.dest, 1'b0, unit_alu0);
		end
	end

	////////////////////
	// Dispatch
	////////////////////

	// Second read port serves src1 or, for stores, the data register
	always_comb begin
		for (int u = 0; u < NUM_UNITS; u++) begin
			disp_go[u] = (units[u].state == st_waiting) && units[u].src[0].ready &&
				units[u].src[1].ready && units[u].src[2].ready;
			rd_addr[2*u] = units[u].src[0].rgn;
			rd_addr[2*u+1] = (units[u].src[1].sel == src_reg) ? units[u].src[1].rgn :
				units[u].src[2].rgn;
			disp_arr[u].valid = disp_go[u];
			disp_arr[u].op = units[u].op;
			disp_arr[u].dest = units[u].dest;
			disp_arr[u].operand_a = src_value(units[u].src[0].sel, rd_data[2*u],
				units[u].imm, units[u].pc);
			disp_arr[u].operand_b = src_value(units[u].src[1].sel, rd_data[2*u+1],
				units[u].imm, units[u].pc);
			disp_arr[u].store_data = rd_data[2*u+1];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int u = 0; u < NUM_UNITS; u++) begin
				units[u] <= '0;
			end
			for (int r = 0; r < NUM_REGS; r++) begin
				pend_valid[r] <= 1'b0;
				pend_unit[r] <= unit_alu0;
			end
		end else begin
			// Completions free the unit and wake up waiting sources
			for (int u = 0; u < NUM_UNITS; u++) begin
				if (finish[u]) begin
					units[u].state <= st_idle;
				end
				if (disp_go[u]) begin
					units[u].state <= st_executing;
				end
				for (int k = 0; k < 3; k++) begin
					if (!units[u].src[k].ready && done_arr[units[u].src[k].producer].valid) begin
						units[u].src[k].ready <= 1'b1;
					end
				end
			end
			for (int r = 0; r < NUM_REGS; r++) begin
				if (pend_valid[r] && done_arr[pend_unit[r]].valid &&
						done_arr[pend_unit[r]].dest == reg_addr_t'(r)) begin
					pend_valid[r] <= 1'b0;
				end
			end

			if (issue) begin
				units[target] <= new_entry;
				if (writes_dest) begin
					pend_valid[decoded.dest] <= 1'b1;
					pend_unit[decoded.dest] <= target;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== execute/alu_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_unit
	import cpu_pkg::*;
(
	input  wire logic      clk,
	input  wire logic      rst_n,
	input  wire dispatch_t disp,
	output complete_t      done
);

	logic      valid_q;
	op_e       op_q;
	reg_addr_t dest_q;
	word_t     a_q;
	word_t     b_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= disp.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (disp.valid) begin
			op_q <= disp.op;
			dest_q <= disp.dest;
			a_q <= disp.operand_a;
			b_q <= disp.operand_b;
		end
	end

	// Result comes straight off the input registers
	always_comb begin
		done.valid = valid_q;
		done.dest = dest_q;
		done.value = (op_q == op_sub) ? a_q - b_q : a_q + b_q;
	end

endmodule

`default_nettype wire

// ==== execute/mem_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_unit
	import cpu_pkg::*;
#(
	parameter int MEM_LATENCY = 3,
	parameter int DMEM_WORDS = 256
)
(
	input  wire logic      clk,
	input  wire logic      rst_n,
	input  wire dispatch_t disp,
	output complete_t      done,
	output store_t         store
);

	localparam int AW = $clog2(DMEM_WORDS);
	localparam int CW = $clog2(MEM_LATENCY + 1);

	logic          busy;
	logic [CW-1:0] cnt;
	logic          finish;
	logic          is_store_q;
	reg_addr_t     dest_q;
	word_t         addr_q;
	word_t         data_q;
	word_t         sum;
	word_t         ram [DMEM_WORDS];

	assign sum = disp.operand_a + disp.operand_b;
	assign finish = busy && (cnt == CW'(MEM_LATENCY));

	// Cycle count starts at 1 on the edge after dispatch
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cnt <= '0;
		end else if (disp.valid) begin
			busy <= 1'b1;
			cnt <= CW'(1);
		end else if (finish) begin
			busy <= 1'b0;
		end else if (busy) begin
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (disp.valid) begin
			is_store_q <= (disp.op == op_store);
			dest_q <= disp.dest;
			addr_q <= word_t'(sum % DMEM_WORDS);
			data_q <= disp.store_data;
		end
	end

	////////////////////
	// Data RAM
	////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DMEM_WORDS; i++) begin
				ram[i] <= '0;
			end
		end else if (finish && is_store_q) begin
			ram[addr_q[AW-1:0]] <= data_q;
		end
	end

	always_comb begin
		done.valid = finish && !is_store_q;
		done.dest = dest_q;
		done.value = ram[addr_q[AW-1:0]];
		store.valid = finish && is_store_q;
		store.addr = addr_q;
		store.data = data_q;
	end

endmodule

`default_nettype wire

// ==== design/register_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module register_file
	import cpu_pkg::*;
(
	input  wire logic      clk,
	input  wire logic      rst_n,
	input  wire complete_t wr [NUM_UNITS],
	input  wire reg_addr_t rd_addr [NUM_RD_PORTS],
	output word_t          rd_data [NUM_RD_PORTS],
	input  wire reg_addr_t dbg_addr,
	output word_t          dbg_value
);

	word_t regs [NUM_REGS];

	// One pending writer per register, so ports never hit the same entry
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < NUM_REGS; r++) begin
				regs[r] <= '0;
			end
		end else begin
			for (int p = 0; p < NUM_UNITS; p++) begin
				if (wr[p].valid) begin
					regs[wr[p].dest] <= wr[p].value;
				end
			end
		end
	end

	always_comb begin
		for (int p = 0; p < NUM_RD_PORTS; p++) begin
			rd_data[p] = regs[rd_addr[p]];
		end
	end

	assign dbg_value = regs[dbg_addr];

endmodule

`default_nettype wire

// ==== design/cpu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_top
	import cpu_pkg::*;
#(
	parameter int MEM_LATENCY = 3,
	parameter int DMEM_WORDS = 256
)
(
	input  wire logic      clk,
	input  wire logic      rst_n,
	input  wire word_t     instr,
	input  wire reg_addr_t dbg_addr,
	output word_t          fetch_addr,
	output logic           stall,
	output word_t          dbg_value,
	output store_t         store
);

	word_t          held_instr;
	word_t          held_pc;
	logic           held_valid;
	decoded_instr_t decoded;
	dispatch_t      alu0_disp;
	dispatch_t      alu1_disp;
	dispatch_t      mem_disp;
	complete_t      alu0_done;
	complete_t      alu1_done;
	complete_t      mem_done;
	complete_t      wr_ports [NUM_UNITS];
	reg_addr_t      rd_addr [NUM_RD_PORTS];
	word_t          rd_data [NUM_RD_PORTS];

	assign wr_ports[unit_alu0] = alu0_done;
	assign wr_ports[unit_alu1] = alu1_done;
	assign wr_ports[unit_mem0] = mem_done;

	fetch_unit u_fetch (
		.clk        (clk),
		.rst_n      (rst_n),
		.stall      (stall),
		.instr      (instr),
		.fetch_addr (fetch_addr),
		.held_instr (held_instr),
		.held_pc    (held_pc),
		.held_valid (held_valid)
	);

	instr_decoder u_decoder (
		.held_instr (held_instr),
		.held_pc    (held_pc),
		.held_valid (held_valid),
		.decoded    (decoded)
	);

	scoreboard u_scoreboard (
		.clk            (clk),
		.rst_n          (rst_n),
		.decoded        (decoded),
		.alu0_done      (alu0_done),
		.alu1_done      (alu1_done),
		.mem_done       (mem_done),
		.mem_store_done (store.valid),
		.rd_addr        (rd_addr),
		.rd_data        (rd_data),
		.alu0_disp      (alu0_disp),
		.alu1_disp      (alu1_disp),
		.mem_disp       (mem_disp),
		.stall          (stall)
	);

	////////////////////
	// Execution units
	////////////////////

	alu_unit u_alu0 (
		.clk   (clk),
		.rst_n (rst_n),
		.disp  (alu0_disp),
		.done  (alu0_done)
	);

	alu_unit u_alu1 (
		.clk   (clk),
		.rst_n (rst_n),
		.disp  (alu1_disp),
		.done  (alu1_done)
	);

	mem_unit #(
		.MEM_LATENCY (MEM_LATENCY),
		.DMEM_WORDS  (DMEM_WORDS)
	) u_mem (
		.clk   (clk),
		.rst_n (rst_n),
		.disp  (mem_disp),
		.done  (mem_done),
		.store (store)
	);

	register_file u_regfile (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr        (wr_ports),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data),
		.dbg_addr  (dbg_addr),
		.dbg_value (dbg_value)
	);

endmodule

`default_nettype wire

// ==== tb/cpu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_tb
	import cpu_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 8;
	localparam int DRAIN_CYCLES = 40;
	localparam int MEM_LATENCY = 3;
	localparam int DMEM_WORDS = 256;
	localparam int IMEM_WORDS = 64;
	localparam int RANDOM_LEN = 40;
	localparam int NUM_PROGS = 5;
	// Longest program sets the budget of every program
	localparam int WATCHDOG_CYCLES = NUM_PROGS * (RANDOM_LEN * 20 + RESET_CYCLES +
		DRAIN_CYCLES + 2 * NUM_REGS) + 200;
	localparam word_t NOP_WORD = 16'hf800;

	logic      clk;
	logic      rst_n;
	reg_addr_t dbg_addr;
	word_t     instr;
	word_t     fetch_addr;
	logic      stall;
	word_t     dbg_value;
	store_t    store;

	word_t  imem [IMEM_WORDS];
	int     prog_len;
	word_t  gold_regs [NUM_REGS];
	word_t  gold_mem [DMEM_WORDS];
	store_t exp_stores [$];
	int     stall_cycles;
	int     checks;
	int     value_errors;
	int     other_errors;

	cpu_top #(
		.MEM_LATENCY (MEM_LATENCY),
		.DMEM_WORDS  (DMEM_WORDS)
	) u_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.instr      (instr),
		.dbg_addr   (dbg_addr),
		.fetch_addr (fetch_addr),
		.stall      (stall),
		.dbg_value  (dbg_value),
		.store      (store)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Instruction memory answers in the same cycle
	assign instr = (int'(fetch_addr) < prog_len) ? imem[fetch_addr[5:0]] : NOP_WORD;

	function automatic word_t imm_instr(opcode_t opc, int rd, int rs, int imm);
		return {opc, 3'(rd), 3'(rs), 5'(imm)};
	endfunction

	function automatic word_t two_reg_instr(opcode_t opc, int rd, int rs, int rt);
		return {opc, 3'(rd), 3'(rs), 2'b00, 3'(rt)};
	endfunction

	function automatic word_t pc_rel_instr(opcode_t opc, int rd, int offset);
		return {opc, 3'(rd), 8'(offset)};
	endfunction

	task automatic append_instr(word_t w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	task automatic check_value(string name, word_t got, word_t expected);
		checks++;
		assert (got === expected) else begin
			value_errors++;
			$display("error %s: got %h, expected %h", name, got, expected);
		end
	endtask

	////////////////////
	// Golden model
	////////////////////

	task automatic record_store(word_t addr, word_t data);
		int     idx;
		store_t st;
		idx = int'(addr) % DMEM_WORDS;
		gold_mem[idx] = data;
		st.valid = 1'b1;
		st.addr = word_t'(idx);
		st.data = data;
		exp_stores.push_back(st);
	endtask

	task automatic run_golden();
		word_t     w;
		word_t     rs_val;
		word_t     i5;
		word_t     i8;
		word_t     base_addr;
		word_t     pc_addr;
		reg_addr_t rd;
		for (int r = 0; r < NUM_REGS; r++) begin
			gold_regs[r] = '0;
		end
		for (int m = 0; m < DMEM_WORDS; m++) begin
			gold_mem[m] = '0;
		end
		exp_stores.delete();
		for (int pc = 0; pc < prog_len; pc++) begin
			w = imem[pc];
			rd = w[10:8];
			rs_val = gold_regs[w[7:5]];
			i5 = word_t'($signed(w[4:0]));
			i8 = word_t'($signed(w[7:0]));
			base_addr = rs_val + i5;
			pc_addr = word_t'(pc) + 16'd1 + i8;
			case (w[15:11])
				OPC_ADD_IMM: gold_regs[rd] = rs_val + i5;
				OPC_ADD_REG: gold_regs[rd] = rs_val + gold_regs[w[2:0]];
				OPC_SUB_IMM: gold_regs[rd] = rs_val - i5;
				OPC_SUB_REG: gold_regs[rd] = rs_val - gold_regs[w[2:0]];
				OPC_LD_BASE: gold_regs[rd] = gold_mem[int'(base_addr) % DMEM_WORDS];
				OPC_LD_PC: gold_regs[rd] = gold_mem[int'(pc_addr) % DMEM_WORDS];
				OPC_ST_BASE: record_store(base_addr, gold_regs[rd]);
				OPC_ST_PC: record_store(pc_addr, gold_regs[rd]);
				default: ;
			endcase
		end
	endtask

	////////////////////
	// Programs
	////////////////////

	task automatic independent_program();
		append_instr(imm_instr(OPC_ADD_IMM, 1, 0, 3));
		append_instr(imm_instr(OPC_ADD_IMM, 2, 0, 10));
		append_instr(imm_instr(OPC_SUB_IMM, 3, 0, 6));
		append_instr(imm_instr(OPC_ADD_IMM, 4, 0, -16));
		append_instr(imm_instr(OPC_SUB_IMM, 5, 0, -1));
		append_instr(imm_instr(OPC_ADD_IMM, 6, 0, 15));
		append_instr(two_reg_instr(OPC_ADD_REG, 7, 1, 2));
		append_instr(two_reg_instr(OPC_SUB_REG, 0, 6, 4));
	endtask

	// Sub waits on a slow load while r2 is rewritten
	task automatic chain_program();
		append_instr(imm_instr(OPC_ADD_IMM, 1, 0, 5));
		append_instr(imm_instr(OPC_ADD_IMM, 2, 1, 1));
		append_instr(two_reg_instr(OPC_ADD_REG, 3, 2, 1));
		append_instr(two_reg_instr(OPC_ADD_REG, 4, 3, 3));
		append_instr(imm_instr(OPC_SUB_IMM, 5, 4, 2));
		append_instr(imm_instr(OPC_LD_BASE, 6, 5, 0));
		append_instr(two_reg_instr(OPC_SUB_REG, 7, 6, 2));
		append_instr(imm_instr(OPC_ADD_IMM, 2, 0, -7));
		append_instr(two_reg_instr(OPC_ADD_REG, 1, 2, 7));
	endtask

	task automatic store_program();
		append_instr(imm_instr(OPC_ADD_IMM, 1, 0, 5));
		append_instr(imm_instr(OPC_ADD_IMM, 2, 0, 12));
		append_instr(imm_instr(OPC_SUB_IMM, 3, 0, 9));
		append_instr(imm_instr(OPC_ST_BASE, 1, 2, 3));
		append_instr(pc_rel_instr(OPC_ST_PC, 3, 20));
		append_instr(imm_instr(OPC_ST_BASE, 2, 1, -2));
		append_instr(pc_rel_instr(OPC_ST_PC, 1, -4));
		append_instr(two_reg_instr(OPC_ADD_REG, 4, 1, 3));
		append_instr(imm_instr(OPC_ST_BASE, 4, 0, 0));
	endtask

	task automatic load_program();
		append_instr(imm_instr(OPC_ADD_IMM, 1, 0, 7));
		append_instr(imm_instr(OPC_ADD_IMM, 2, 0, -3));
		append_instr(two_reg_instr(OPC_ADD_REG, 3, 1, 2));
		append_instr(imm_instr(OPC_ST_BASE, 1, 3, 1));
		append_instr(pc_rel_instr(OPC_ST_PC, 2, 10));
		append_instr(imm_instr(OPC_LD_BASE, 5, 3, 1));
		append_instr(pc_rel_instr(OPC_LD_PC, 6, 8));
		append_instr(imm_instr(OPC_LD_BASE, 7, 0, 5));
		append_instr(two_reg_instr(OPC_ADD_REG, 4, 5, 6));
	endtask

	task automatic random_program();
		opcode_t opc_table [9];
		int      pick;
		opc_table = '{OPC_ADD_IMM, OPC_ADD_REG, OPC_SUB_IMM, OPC_SUB_REG, OPC_LD_BASE,
			OPC_LD_PC, OPC_ST_BASE, OPC_ST_PC, 5'b11111};
		for (int i = 0; i < RANDOM_LEN; i++) begin
			pick = $urandom_range(8, 0);
			append_instr({opc_table[pick], 11'($urandom())});
		end
	endtask

	////////////////////
	// Sequencing
	////////////////////

	task automatic enter_reset();
		@(posedge clk);
		#2;
		rst_n = 1'b0;
		prog_len = 0;
	endtask

	// Reset state is checked while rst_n is still low
	task automatic leave_reset();
		for (int r = 0; r < NUM_REGS; r++) begin
			dbg_addr = reg_addr_t'(r);
			@(negedge clk);
			check_value("fetch_addr", fetch_addr, '0);
			check_value("stall", word_t'(stall), '0);
			check_value("store.valid", word_t'(store.valid), '0);
			check_value($sformatf("dbg_value r%0d", r), dbg_value, '0);
			@(posedge clk);
			#2;
		end
		stall_cycles = 0;
		rst_n = 1'b1;
	endtask

	task automatic finish_program(string name);
		do begin
			@(negedge clk);
		end while (int'(fetch_addr) <= prog_len);
		repeat (DRAIN_CYCLES) @(negedge clk);
		for (int r = 0; r < NUM_REGS; r++) begin
			@(posedge clk);
			#2;
			dbg_addr = reg_addr_t'(r);
			@(negedge clk);
			check_value($sformatf("dbg_value r%0d", r), dbg_value, gold_regs[r]);
		end
		checks++;
		assert (exp_stores.size() == 0) else begin
			other_errors++;
			$display("%s: %0d expected stores never appeared", name, exp_stores.size());
		end
	endtask

	task automatic run_test(int prog, string name);
		enter_reset();
		case (prog)
			0: independent_program();
			1: chain_program();
			2: store_program();
			3: load_program();
			default: random_program();
		endcase
		run_golden();
		leave_reset();
		finish_program(name);
	endtask

	// Stores must match the model list in order
	initial begin
		store_t exp_store;
		forever begin
			@(negedge clk);
			if (store.valid) begin
				checks++;
				assert (exp_stores.size() > 0) else begin
					other_errors++;
					$display("unexpected store to address %h with data %h", store.addr,
						store.data);
				end
				if (exp_stores.size() > 0) begin
					exp_store = exp_stores.pop_front();
					check_value("store.addr", store.addr, exp_store.addr);
					check_value("store.data", store.data, exp_store.data);
				end
			end
		end
	end

	initial begin
		forever begin
			@(negedge clk);
			if (rst_n && stall) begin
				stall_cycles++;
			end
		end
	end

	initial begin
		void'($urandom(32'h3fe2_106c));
		rst_n = 1'b0;
		dbg_addr = '0;
		prog_len = 0;
		stall_cycles = 0;
		checks = 0;
		value_errors = 0;
		other_errors = 0;
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = NOP_WORD;
		end

		run_test(0, "independent add/sub");
		run_test(1, "dependent chain");
		checks++;
		assert (stall_cycles > 0) else begin
			other_errors++;
			$display("stall never went high during the dependent chain");
		end
		run_test(2, "stores");
		run_test(3, "loads after stores");
		run_test(4, "random program");

		$display("checks %0d, value errors %0d, other failures %0d", checks, value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		other_errors++;
		$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("checks %0d, value errors %0d, other failures %0d", checks, value_errors,
			other_errors);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
common/cpu_pkg.sv
design/fetch_unit.sv
decode/instr_decoder.sv
decode/scoreboard.sv
execute/alu_unit.sv
execute/mem_unit.sv
design/register_file.sv
design/cpu_top.sv
tb/cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module cpu_tb --Mdir obj_dir -o cpu_tb_sim

./obj_dir/cpu_tb_sim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
	echo "simulation result: pass"
	exit 0
else
	echo "simulation result: fail"
	exit 1
fi
